/* tlb_pkg.sv */
package tlb_pkg;

    // Virtual page number carried by every entry
    localparam int vpn_w = 20;

    // Bit positions of the per-entry flags
    localparam int flag_writable = 0;
    localparam int flag_present = 1;
    localparam int flag_pcd = 2;
    localparam int flag_w = 3;

    // Entry index width of at least one bit
    function automatic int tlb_idx_w(input int entries);
        int w;
        w = 1;
        if (entries > 1) begin
            w = $clog2(entries);
        end
        return w;
    endfunction

endpackage

/* access_split_pkg.sv */
package access_split_pkg;

    // Address, line and page geometry
    localparam int addr_w = 32;
    localparam int line_bytes = 16;
    localparam int line_off_w = 4;
    localparam int line_num_w = addr_w - line_off_w;
    localparam int page_off_w = 12;

    // Widest access accepted, in bytes
    localparam int max_access_bytes = 8;

    // Access size codes
    localparam logic [1:0] size_1 = 2'd0;
    localparam logic [1:0] size_2 = 2'd1;
    localparam logic [1:0] size_4 = 2'd2;
    localparam logic [1:0] size_8 = 2'd3;

    // One virtual address seen as page number/offset or as line number/offset
    typedef union packed {
        struct packed {
            logic [tlb_pkg::vpn_w-1:0] vpn;
            logic [page_off_w-1:0] offset;
        } page;
        struct packed {
            logic [line_num_w-1:0] num;
            logic [line_off_w-1:0] offset;
        } line;
    } vaddr_u;

    // Byte count of a size code
    function automatic logic [line_off_w-1:0] size_bytes(input logic [1:0] size);
        logic [line_off_w-1:0] n;
        n = '0;
        case (size)
            size_1: n = 4'd1;
            size_2: n = 4'd2;
            size_4: n = 4'd4;
            size_8: n = 4'd8;
        endcase
        return n;
    endfunction

endpackage

/* tlb_entry_file.sv */
`timescale 1ns/1ps

module tlb_entry_file
    import tlb_pkg::*;
#(
    parameter int tlb_entries = 8,
    parameter int pfn_w = 3
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            tlb_write,
    input  logic [tlb_idx_w(tlb_entries)-1:0] tlb_index,
    input  logic [vpn_w-1:0]                tlb_vpn,
    input  logic [pfn_w-1:0]                tlb_pfn,
    input  logic                            tlb_valid,
    input  logic                            tlb_present,
    input  logic                            tlb_writable,
    input  logic                            tlb_pcd,
    output logic [tlb_entries*vpn_w-1:0]    entry_vpn,
    output logic [tlb_entries*pfn_w-1:0]    entry_pfn,
    output logic [tlb_entries-1:0]          entry_valid,
    output logic [tlb_entries-1:0]          entry_present,
    output logic [tlb_entries-1:0]          entry_writable,
    output logic [tlb_entries-1:0]          entry_pcd
);

    logic [vpn_w-1:0] vpn_q [tlb_entries];
    logic [pfn_w-1:0] pfn_q [tlb_entries];
    logic [flag_w-1:0] flags_q [tlb_entries];
    logic [tlb_entries-1:0] valid_q;
    logic [flag_w-1:0] flags_in;

    assign flags_in[flag_writable] = tlb_writable;
    assign flags_in[flag_present] = tlb_present;
    assign flags_in[flag_pcd] = tlb_pcd;

    // Only the valid bits need clearing
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (tlb_write) begin
            valid_q[tlb_index] <= tlb_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_write) begin
            vpn_q[tlb_index] <= tlb_vpn;
            pfn_q[tlb_index] <= tlb_pfn;
            flags_q[tlb_index] <= flags_in;
        end
    end

    assign entry_valid = valid_q;

    // Flatten for the parallel lookups
    for (genvar i = 0; i < tlb_entries; i++) begin : g_flat
        assign entry_vpn[i*vpn_w +: vpn_w] = vpn_q[i];
        assign entry_pfn[i*pfn_w +: pfn_w] = pfn_q[i];
        assign entry_present[i] = flags_q[i][flag_present];
        assign entry_writable[i] = flags_q[i][flag_writable];
        assign entry_pcd[i] = flags_q[i][flag_pcd];
    end

endmodule

/* page_lookup.sv */
`timescale 1ns/1ps

module page_lookup
    import access_split_pkg::*;
    import tlb_pkg::*;
#(
    parameter int tlb_entries = 8,
    parameter int pfn_w = 3
) (
    input  vaddr_u                          vaddr,
    input  logic                            write,
    input  logic [tlb_entries*vpn_w-1:0]    entry_vpn,
    input  logic [tlb_entries*pfn_w-1:0]    entry_pfn,
    input  logic [tlb_entries-1:0]          entry_valid,
    input  logic [tlb_entries-1:0]          entry_present,
    input  logic [tlb_entries-1:0]          entry_writable,
    input  logic [tlb_entries-1:0]          entry_pcd,
    output logic                            hit,
    output logic [pfn_w-1:0]                pfn,
    output logic                            fault,
    output logic                            pcd
);

    logic [tlb_entries-1:0] match;
    logic sel_present;
    logic sel_writable;
    logic sel_pcd;

    for (genvar i = 0; i < tlb_entries; i++) begin : g_match
        assign match[i] = entry_valid[i] && (entry_vpn[i*vpn_w +: vpn_w] == vaddr.page.vpn);
    end

    // Walk down so the lowest matching index is taken last
    always_comb begin
        hit = 1'b0;
        pfn = '0;
        sel_present = 1'b0;
        sel_writable = 1'b0;
        sel_pcd = 1'b0;
        for (int i = tlb_entries - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit = 1'b1;
                pfn = entry_pfn[i*pfn_w +: pfn_w];
                sel_present = entry_present[i];
                sel_writable = entry_writable[i];
                sel_pcd = entry_pcd[i];
            end
        end
    end

    // Not present, or a store to a read-only page
    assign fault = hit && (!sel_present || (write && !sel_writable));
    assign pcd = hit && sel_pcd;

endmodule

/* byte_lane_aligner.sv */
`timescale 1ns/1ps

module byte_lane_aligner
    import access_split_pkg::*;
(
    input  vaddr_u                          vaddr,
    input  logic [1:0]                      size,
    input  logic [max_access_bytes*8-1:0]   data,
    output vaddr_u                          line1_vaddr,
    output logic                            crosses,
    output logic [line_bytes-1:0]           mask0,
    output logic [line_bytes-1:0]           mask1,
    output logic [line_bytes*8-1:0]         data0,
    output logic [line_bytes*8-1:0]         data1
);

    localparam int pos_w = line_off_w + 1;
    localparam int sel_w = $clog2(max_access_bytes);
    localparam logic [pos_w-1:0] line_end = pos_w'(line_bytes);
    localparam logic [pos_w-1:0] data_end = pos_w'(max_access_bytes);

    // One spare bit so offset plus size never wraps
    logic [pos_w-1:0] offset;
    logic [pos_w-1:0] nbytes;
    logic [pos_w-1:0] end_pos;
    logic [line_num_w-1:0] next_line;

    assign offset = {1'b0, vaddr.line.offset};
    assign nbytes = {1'b0, size_bytes(size)};
    assign end_pos = offset + nbytes;
    assign crosses = end_pos > line_end;

    // Start of the following line
    assign next_line = vaddr.line.num + 1'b1;
    assign line1_vaddr = {next_line, {line_off_w{1'b0}}};

    for (genvar lane = 0; lane < line_bytes; lane++) begin : g_lane
        localparam logic [pos_w-1:0] lane_pos = pos_w'(lane);
        logic [pos_w-1:0] idx0;
        logic [pos_w-1:0] idx1;
        logic in0;
        logic take0;
        logic take1;

        // Index of the access byte that lands on this lane
        assign idx0 = lane_pos - offset;
        assign idx1 = lane_pos + line_end - offset;
        assign in0 = lane_pos >= offset;

        assign mask0[lane] = in0 && (idx0 < nbytes);
        assign mask1[lane] = idx1 < nbytes;

        // Spill-over into the next line starts again at lane 0
        assign take0 = in0 && (idx0 < data_end);
        assign take1 = idx1 < data_end;

        assign data0[lane*8 +: 8] = take0 ? data[idx0[sel_w-1:0]*8 +: 8] : 8'h00;
        assign data1[lane*8 +: 8] = take1 ? data[idx1[sel_w-1:0]*8 +: 8] : 8'h00;
    end

endmodule

/* access_combine.sv */
`timescale 1ns/1ps

module access_combine
    import access_split_pkg::*;
#(
    parameter int pfn_w = 3
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            access_valid,
    input  logic                            access_read,
    input  logic                            access_write,
    input  vaddr_u                          vaddr,
    input  vaddr_u                          line1_vaddr,
    input  logic                            crosses,
    input  logic                            hit0,
    input  logic [pfn_w-1:0]                pfn0,
    input  logic                            fault0,
    input  logic                            pcd0,
    input  logic                            hit1,
    input  logic [pfn_w-1:0]                pfn1,
    input  logic                            fault1,
    input  logic                            pcd1,
    input  logic [line_bytes-1:0]           mask0,
    input  logic [line_bytes-1:0]           mask1,
    input  logic [line_bytes*8-1:0]         data0,
    input  logic [line_bytes*8-1:0]         data1,
    output logic                            done,
    output logic                            line0_valid,
    output logic [pfn_w+page_off_w-1:0]     line0_addr,
    output logic [line_bytes-1:0]           line0_mask,
    output logic [line_bytes*8-1:0]         line0_data,
    output logic                            line1_valid,
    output logic [pfn_w+page_off_w-1:0]     line1_addr,
    output logic [line_bytes-1:0]           line1_mask,
    output logic [line_bytes*8-1:0]         line1_data,
    output logic                            tlb_miss,
    output logic                            protection_fault,
    output logic                            uncacheable
);

    logic req;
    logic miss;
    logic fault;
    logic pcd;
    logic line0_ok;
    logic line1_ok;

    // Line 1 only counts when the access spills into it
    assign miss = !hit0 || (crosses && !hit1);
    assign fault = !miss && (fault0 || (crosses && fault1));
    assign pcd = pcd0 || (crosses && pcd1);

    // Neither read nor write means nothing goes to the cache
    assign req = access_read || access_write;
    assign line0_ok = req && !miss && !fault;
    assign line1_ok = line0_ok && crosses;

    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
            line0_valid <= 1'b0;
            line1_valid <= 1'b0;
            tlb_miss <= 1'b0;
            protection_fault <= 1'b0;
            uncacheable <= 1'b0;
        end else begin
            done <= access_valid;
            line0_valid <= access_valid && line0_ok;
            line1_valid <= access_valid && line1_ok;
            if (access_valid) begin
                tlb_miss <= miss;
                protection_fault <= fault;
                uncacheable <= pcd;
            end
        end
    end

    // Request payload held until the next strobe
    always_ff @(posedge clk) begin
        if (access_valid) begin
            line0_addr <= {pfn0, vaddr.page.offset};
            line1_addr <= {pfn1, line1_vaddr.page.offset};
            line0_mask <= mask0;
            line1_mask <= mask1;
            line0_data <= data0;
            line1_data <= data1;
        end
    end

endmodule

/* access_split_top.sv */
`timescale 1ns/1ps

module access_split_top
    import access_split_pkg::*;
    import tlb_pkg::*;
#(
    parameter int tlb_entries = 8,
    parameter int pfn_w = 3
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            tlb_write,
    input  logic [tlb_idx_w(tlb_entries)-1:0] tlb_index,
    input  logic [vpn_w-1:0]                tlb_vpn,
    input  logic [pfn_w-1:0]                tlb_pfn,
    input  logic                            tlb_valid,
    input  logic                            tlb_present,
    input  logic                            tlb_writable,
    input  logic                            tlb_pcd,
    input  logic                            access_valid,
    input  logic [addr_w-1:0]               access_addr,
    input  logic [1:0]                      access_size,
    input  logic [max_access_bytes*8-1:0]   access_data,
    input  logic                            access_read,
    input  logic                            access_write,
    output logic                            done,
    output logic                            line0_valid,
    output logic [pfn_w+page_off_w-1:0]     line0_addr,
    output logic [line_bytes-1:0]           line0_mask,
    output logic [line_bytes*8-1:0]         line0_data,
    output logic                            line1_valid,
    output logic [pfn_w+page_off_w-1:0]     line1_addr,
    output logic [line_bytes-1:0]           line1_mask,
    output logic [line_bytes*8-1:0]         line1_data,
    output logic                            tlb_miss,
    output logic                            protection_fault,
    output logic                            uncacheable
);

    logic [tlb_entries*vpn_w-1:0] entry_vpn;
    logic [tlb_entries*pfn_w-1:0] entry_pfn;
    logic [tlb_entries-1:0] entry_valid;
    logic [tlb_entries-1:0] entry_present;
    logic [tlb_entries-1:0] entry_writable;
    logic [tlb_entries-1:0] entry_pcd;

    vaddr_u line0_vaddr;
    vaddr_u line1_vaddr;
    logic crosses;
    logic [line_bytes-1:0] mask0;
    logic [line_bytes-1:0] mask1;
    logic [line_bytes*8-1:0] data0;
    logic [line_bytes*8-1:0] data1;

    logic hit0;
    logic [pfn_w-1:0] pfn0;
    logic fault0;
    logic pcd0;
    logic hit1;
    logic [pfn_w-1:0] pfn1;
    logic fault1;
    logic pcd1;

    assign line0_vaddr = access_addr;

    tlb_entry_file #(
        .tlb_entries(tlb_entries),
        .pfn_w(pfn_w)
    ) tlb_entry_file_i (
        .clk(clk),
        .reset(reset),
        .tlb_write(tlb_write),
        .tlb_index(tlb_index),
        .tlb_vpn(tlb_vpn),
        .tlb_pfn(tlb_pfn),
        .tlb_valid(tlb_valid),
        .tlb_present(tlb_present),
        .tlb_writable(tlb_writable),
        .tlb_pcd(tlb_pcd),
        .entry_vpn(entry_vpn),
        .entry_pfn(entry_pfn),
        .entry_valid(entry_valid),
        .entry_present(entry_present),
        .entry_writable(entry_writable),
        .entry_pcd(entry_pcd)
    );

    // Same entry vectors feed both page lookups
    page_lookup #(
        .tlb_entries(tlb_entries),
        .pfn_w(pfn_w)
    ) page_lookup_line0 (
        .vaddr(line0_vaddr),
        .write(access_write),
        .entry_vpn(entry_vpn),
        .entry_pfn(entry_pfn),
        .entry_valid(entry_valid),
        .entry_present(entry_present),
        .entry_writable(entry_writable),
        .entry_pcd(entry_pcd),
        .hit(hit0),
        .pfn(pfn0),
        .fault(fault0),
        .pcd(pcd0)
    );

    page_lookup #(
        .tlb_entries(tlb_entries),
        .pfn_w(pfn_w)
    ) page_lookup_line1 (
        .vaddr(line1_vaddr),
        .write(access_write),
        .entry_vpn(entry_vpn),
        .entry_pfn(entry_pfn),
        .entry_valid(entry_valid),
        .entry_present(entry_present),
        .entry_writable(entry_writable),
        .entry_pcd(entry_pcd),
        .hit(hit1),
        .pfn(pfn1),
        .fault(fault1),
        .pcd(pcd1)
    );

    byte_lane_aligner byte_lane_aligner_i (
        .vaddr(line0_vaddr),
        .size(access_size),
        .data(access_data),
        .line1_vaddr(line1_vaddr),
        .crosses(crosses),
        .mask0(mask0),
        .mask1(mask1),
        .data0(data0),
        .data1(data1)
    );

    access_combine #(
        .pfn_w(pfn_w)
    ) access_combine_i (
        .clk(clk),
        .reset(reset),
        .access_valid(access_valid),
        .access_read(access_read),
        .access_write(access_write),
        .vaddr(line0_vaddr),
        .line1_vaddr(line1_vaddr),
        .crosses(crosses),
        .hit0(hit0),
        .pfn0(pfn0),
        .fault0(fault0),
        .pcd0(pcd0),
        .hit1(hit1),
        .pfn1(pfn1),
        .fault1(fault1),
        .pcd1(pcd1),
        .mask0(mask0),
        .mask1(mask1),
        .data0(data0),
        .data1(data1),
        .done(done),
        .line0_valid(line0_valid),
        .line0_addr(line0_addr),
        .line0_mask(line0_mask),
        .line0_data(line0_data),
        .line1_valid(line1_valid),
        .line1_addr(line1_addr),
        .line1_mask(line1_mask),
        .line1_data(line1_data),
        .tlb_miss(tlb_miss),
        .protection_fault(protection_fault),
        .uncacheable(uncacheable)
    );

endmodule

/* access_split_tb.sv */
`timescale 1ns/1ps

module access_split_tb;

    localparam int pfn_w = 3;
    localparam int timeout_cycles = 20;
    localparam int num_pages = 6;
    localparam int num_rows = 16;

    typedef struct packed {
        logic [19:0] vpn;
        logic [2:0] pfn;
        logic present;
        logic writable;
        logic pcd;
    } page_t;

    // Address, size code, write, reload of entry 0, then expected miss fault uncacheable
    typedef struct packed {
        logic [31:0] addr;
        logic [1:0] size;
        logic write;
        logic reload;
        logic miss;
        logic fault;
        logic pcd;
    } row_t;

    // Entry number is the table index
    page_t pages [num_pages] = '{
        '{20'h00010, 3'd1, 1'b1, 1'b1, 1'b0},
        '{20'h00011, 3'd2, 1'b1, 1'b1, 1'b0},
        '{20'h00020, 3'd3, 1'b1, 1'b0, 1'b0},
        '{20'h00030, 3'd4, 1'b1, 1'b1, 1'b1},
        '{20'h00040, 3'd5, 1'b0, 1'b1, 1'b0},
        '{20'h0002f, 3'd6, 1'b1, 1'b1, 1'b0}
    };

    row_t rows [num_rows] = '{
        // Inside one line
        '{32'h0001_0040, 2'd2, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0},
        '{32'h0001_0108, 2'd3, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
        // Line crossings at offsets 9 to 15
        '{32'h0001_0209, 2'd3, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0},
        '{32'h0001_030d, 2'd2, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0},
        '{32'h0001_040f, 2'd1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0},
        '{32'h0001_050f, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{32'h0001_060c, 2'd3, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0},
        '{32'h0001_070e, 2'd2, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
        // Page crossings with the second page mapped then unmapped
        '{32'h0001_0ffc, 2'd3, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0},
        '{32'h0001_1ffa, 2'd3, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0},
        // Read-only and not-present pages
        '{32'h0002_0080, 2'd2, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0},
        '{32'h0002_0084, 2'd2, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{32'h0004_0010, 2'd1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0},
        // Cache-disabled page through line 0 and then line 1
        '{32'h0003_0020, 2'd3, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1},
        '{32'h0002_fffe, 2'd2, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1},
        '{32'h0001_0044, 2'd2, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0}
    };

    logic clk;
    logic reset;
    logic tlb_write;
    logic [2:0] tlb_index;
    logic [19:0] tlb_vpn;
    logic [pfn_w-1:0] tlb_pfn;
    logic tlb_valid;
    logic tlb_present;
    logic tlb_writable;
    logic tlb_pcd;
    logic access_valid;
    logic [31:0] access_addr;
    logic [1:0] access_size;
    logic [63:0] access_data;
    logic access_read;
    logic access_write;
    logic done;
    logic line0_valid;
    logic [pfn_w+11:0] line0_addr;
    logic [15:0] line0_mask;
    logic [127:0] line0_data;
    logic line1_valid;
    logic [pfn_w+11:0] line1_addr;
    logic [15:0] line1_mask;
    logic [127:0] line1_data;
    logic tlb_miss;
    logic protection_fault;
    logic uncacheable;

    logic [31:0] lfsr_state;
    logic timed_out;
    int errors;
    int row_errors;
    int rows_ok;
    int rows_bad;

    access_split_top #(
        .tlb_entries(8),
        .pfn_w(pfn_w)
    ) access_split_top_i (
        .clk(clk),
        .reset(reset),
        .tlb_write(tlb_write),
        .tlb_index(tlb_index),
        .tlb_vpn(tlb_vpn),
        .tlb_pfn(tlb_pfn),
        .tlb_valid(tlb_valid),
        .tlb_present(tlb_present),
        .tlb_writable(tlb_writable),
        .tlb_pcd(tlb_pcd),
        .access_valid(access_valid),
        .access_addr(access_addr),
        .access_size(access_size),
        .access_data(access_data),
        .access_read(access_read),
        .access_write(access_write),
        .done(done),
        .line0_valid(line0_valid),
        .line0_addr(line0_addr),
        .line0_mask(line0_mask),
        .line0_data(line0_data),
        .line1_valid(line1_valid),
        .line1_addr(line1_addr),
        .line1_mask(line1_mask),
        .line1_data(line1_data),
        .tlb_miss(tlb_miss),
        .protection_fault(protection_fault),
        .uncacheable(uncacheable)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_data(output logic [63:0] d);
        for (int b = 0; b < 64; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            d[b] = lfsr_state[0];
        end
    endtask

    // Lowest matching entry wins and the top bit is the hit
    function automatic logic [pfn_w:0] translate(input logic [19:0] vpn);
        logic found;
        logic [pfn_w-1:0] pfn;
        found = 1'b0;
        pfn = '0;
        for (int i = 0; i < num_pages; i++) begin
            if (!found && pages[i].vpn == vpn) begin
                found = 1'b1;
                pfn = pages[i].pfn;
            end
        end
        return {found, pfn};
    endfunction

    task automatic load_entry(input int idx);
        tlb_write = 1'b1;
        tlb_index = idx[2:0];
        tlb_vpn = pages[idx].vpn;
        tlb_pfn = pages[idx].pfn;
        tlb_valid = 1'b1;
        tlb_present = pages[idx].present;
        tlb_writable = pages[idx].writable;
        tlb_pcd = pages[idx].pcd;
        @(negedge clk);
        tlb_write = 1'b0;
    endtask

    task automatic compare_field(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            row_errors++;
        end
    endtask

    task automatic run_row(input int r);
        row_t row;
        logic [63:0] data;
        logic [127:0] exp_data0;
        logic [127:0] exp_data1;
        logic [15:0] exp_mask0;
        logic [15:0] exp_mask1;
        logic [31:0] next_addr;
        logic [pfn_w:0] tr0;
        logic [pfn_w:0] tr1;
        logic crosses;
        logic exp_valid0;
        logic exp_valid1;
        int offset;
        int nbytes;
        int pos;
        int waits;

        row = rows[r];
        row_errors = 0;
        data = '0;
        if (row.reload) begin
            pages[0].pfn = 3'd7;
            load_entry(0);
        end
        if (row.write) begin
            draw_data(data);
        end

        // All eight bytes are placed but masks cover only the access size
        offset = int'(row.addr[3:0]);
        nbytes = 1 << row.size;
        exp_data0 = '0;
        exp_data1 = '0;
        exp_mask0 = '0;
        exp_mask1 = '0;
        for (int i = 0; i < 8; i++) begin
            pos = offset + i;
            if (pos < 16) begin
                exp_data0[pos*8 +: 8] = data[i*8 +: 8];
                exp_mask0[pos] = (i < nbytes);
            end else begin
                exp_data1[(pos-16)*8 +: 8] = data[i*8 +: 8];
                exp_mask1[pos-16] = (i < nbytes);
            end
        end
        crosses = (offset + nbytes) > 16;
        next_addr = {row.addr[31:4] + 28'd1, 4'h0};
        tr0 = translate(row.addr[31:12]);
        tr1 = translate(next_addr[31:12]);
        exp_valid0 = !row.miss && !row.fault;
        exp_valid1 = exp_valid0 && crosses;

        access_valid = 1'b1;
        access_addr = row.addr;
        access_size = row.size;
        access_data = data;
        access_read = !row.write;
        access_write = row.write;
        waits = 0;
        while (waits < timeout_cycles && (waits == 0 || !done)) begin
            @(negedge clk);
            access_valid = 1'b0;
            waits++;
        end

        if (!done) begin
            $display("Row %0d never raised done within %0d cycles", r, timeout_cycles);
            timed_out = 1'b1;
        end else begin
            if (waits != 1) begin
                $display("Row %0d raised done after %0d cycles instead of one", r, waits);
                row_errors++;
            end
            compare_field("line0_valid", 128'(line0_valid), 128'(exp_valid0));
            compare_field("line1_valid", 128'(line1_valid), 128'(exp_valid1));
            compare_field("tlb_miss", 128'(tlb_miss), 128'(row.miss));
            compare_field("protection_fault", 128'(protection_fault), 128'(row.fault));
            compare_field("uncacheable", 128'(uncacheable), 128'(row.pcd));
            compare_field("line0_mask", 128'(line0_mask), 128'(exp_mask0));
            compare_field("line1_mask", 128'(line1_mask), 128'(exp_mask1));
            compare_field("line0_data", line0_data, exp_data0);
            compare_field("line1_data", line1_data, exp_data1);
            if (exp_valid0) begin
                compare_field("line0_addr", 128'(line0_addr),
                              128'({tr0[pfn_w-1:0], row.addr[11:0]}));
            end
            if (exp_valid1) begin
                compare_field("line1_addr", 128'(line1_addr),
                              128'({tr1[pfn_w-1:0], next_addr[11:0]}));
            end
        end

        errors += row_errors;
        if (row_errors == 0 && !timed_out) begin
            rows_ok++;
        end else begin
            rows_bad++;
        end
        $display("row %0d addr %h size %0d %s: %s", r, row.addr, nbytes,
                 row.write ? "write" : "read",
                 (row_errors == 0 && !timed_out) ? "ok" : "mismatch");
    endtask

    initial begin
        reset = 1'b1;
        tlb_write = 1'b0;
        tlb_index = '0;
        tlb_vpn = '0;
        tlb_pfn = '0;
        tlb_valid = 1'b0;
        tlb_present = 1'b0;
        tlb_writable = 1'b0;
        tlb_pcd = 1'b0;
        access_valid = 1'b0;
        access_addr = '0;
        access_size = '0;
        access_data = '0;
        access_read = 1'b0;
        access_write = 1'b0;
        lfsr_state = 32'h31a4;
        timed_out = 1'b0;
        errors = 0;
        rows_ok = 0;
        rows_bad = 0;

        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        if (done || line0_valid || line1_valid || tlb_miss || protection_fault
                || uncacheable) begin
            $display("Result outputs are not low after reset");
            errors++;
        end

        for (int i = 0; i < num_pages; i++) begin
            load_entry(i);
        end
        for (int r = 0; r < num_rows && !timed_out; r++) begin
            run_row(r);
        end

        $display("rows %0d, ok %0d, with errors %0d, error count %0d",
                 rows_ok + rows_bad, rows_ok, rows_bad, errors);
        if (errors == 0 && rows_bad == 0 && !timed_out) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* access_split.f */
tlb_pkg.sv
access_split_pkg.sv
tlb_entry_file.sv
page_lookup.sv
byte_lane_aligner.sv
access_combine.sv
access_split_top.sv
access_split_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module access_split_tb \
    -f access_split.f -o access_split_sim

output=$(./obj_dir/access_split_sim)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1
